/* verilog/core_cfg.svh */
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

`define XLEN        32
`define START_ADDR  32'h0000_0000

// addi x0, x0, 0
`define NOP_INST    32'h0000_0013

// keys are {funct7, funct3, opcode}
`define OPC_ADD     17'b0000000_000_0110011
`define OPC_SUB     17'b0100000_000_0110011
`define OPC_AND     17'b0000000_111_0110011
`define OPC_OR      17'b0000000_110_0110011
`define OPC_XOR     17'b0000000_100_0110011
`define OPC_ADDI    17'b0000000_000_0010011
`define OPC_LUI     17'b0000000_000_0110111
`define OPC_JAL     17'b0000000_000_1101111
`define OPC_BEQ     17'b0000000_000_1100011
`define OPC_BNE     17'b0000000_001_1100011
`define OPC_SW      17'b0000000_010_0100011

`endif

/* verilog/core_pkg.sv */
`include "core_cfg.svh"
`default_nettype none

package core_pkg;

    // data and address word
    typedef logic [`XLEN-1:0] word_t;

    // register index
    typedef logic [4:0] reg_addr_t;

    // {funct7, funct3, opcode}
    typedef logic [16:0] opcode_t;

    typedef logic [3:0] strb_t;

    typedef enum logic {
        FETCH_RUN,
        FETCH_REDIRECT
    } fetch_state_e;

endpackage

`default_nettype wire

/* verilog/fetch.sv */
`include "core_cfg.svh"
`default_nettype none

module fetch import core_pkg::*; #(
    parameter word_t start_addr = `START_ADDR
) (
    input  wire        clk,
    input  wire        arst_n,
    input  wire        mem_wait,
    input  wire        flush,
    input  wire word_t flush_pc,
    output logic       inst_rden,
    output word_t      inst_riaddr,
    input  wire        inst_rvalid,
    input  wire word_t inst_roaddr,
    input  wire word_t inst_rdata,
    output logic       fetch_valid,
    output word_t      fetch_pc,
    output word_t      fetch_inst
);

    fetch_state_e state;
    word_t        pc;
    word_t        exp_addr;
    logic         keep;
    logic         buf_valid;
    word_t        buf_pc;
    word_t        buf_inst;

    // drop anything that is not the next expected word
    assign keep = inst_rvalid && (inst_roaddr == exp_addr);

    // after a redirect only the target goes out until it comes back
    assign inst_rden   = !mem_wait && !flush &&
                         (state == FETCH_RUN || pc == exp_addr || keep);
    assign inst_riaddr = pc;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= FETCH_RUN;
            pc       <= start_addr;
            exp_addr <= start_addr;
        end else if (flush) begin
            state    <= FETCH_REDIRECT;
            pc       <= flush_pc;
            exp_addr <= flush_pc;
        end else begin
            if (inst_rden) begin
                pc <= pc + 32'd4;
            end
            if (keep) begin
                exp_addr <= exp_addr + 32'd4;
                state    <= FETCH_RUN;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            buf_valid   <= 1'b0;
            fetch_valid <= 1'b0;
        end else if (flush) begin
            buf_valid   <= 1'b0;
            fetch_valid <= 1'b0;
        end else if (mem_wait) begin
            // the last request may still answer during the hold
            if (keep) begin
                buf_valid <= 1'b1;
            end
        end else begin
            buf_valid   <= 1'b0;
            fetch_valid <= buf_valid || keep;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_wait) begin
            if (keep) begin
                buf_pc   <= inst_roaddr;
                buf_inst <= inst_rdata;
            end
        end else if (buf_valid) begin
            fetch_pc   <= buf_pc;
            fetch_inst <= buf_inst;
        end else begin
            fetch_pc   <= inst_roaddr;
            fetch_inst <= inst_rdata;
        end
    end

endmodule

`default_nettype wire

/* verilog/decode.sv */
`include "core_cfg.svh"
`default_nettype none

module decode import core_pkg::*; (
    input  wire        clk,
    input  wire        arst_n,
    input  wire        mem_wait,
    input  wire        flush,
    input  wire        fetch_valid,
    input  wire word_t fetch_pc,
    input  wire word_t fetch_inst,
    output logic       dec_valid,
    output word_t      dec_pc,
    output opcode_t    dec_opcode,
    output reg_addr_t  dec_rd,
    output reg_addr_t  dec_rs1,
    output reg_addr_t  dec_rs2,
    output word_t      dec_imm
);

    word_t sel;
    word_t imm;
    logic  known;

    function automatic opcode_t inst_key(input word_t i);
        opcode_t k;
        case (i[6:0])
            7'b0110011: k = {i[31:25], i[14:12], i[6:0]};
            7'b0110111,
            7'b1101111: k = {10'b0, i[6:0]};
            default:    k = {7'b0, i[14:12], i[6:0]};
        endcase
        return k;
    endfunction

    always_comb begin
        case (inst_key(fetch_inst))
            `OPC_ADD, `OPC_SUB, `OPC_AND, `OPC_OR, `OPC_XOR,
            `OPC_ADDI, `OPC_LUI, `OPC_JAL, `OPC_BEQ, `OPC_BNE,
            `OPC_SW: known = 1'b1;
            default: known = 1'b0;
        endcase
    end

    // flushed or unknown words go down as a nop
    assign sel = (flush || !known) ? `NOP_INST : fetch_inst;

    always_comb begin
        case (sel[6:0])
            7'b0110111: imm = {sel[31:12], 12'b0};
            7'b1101111: imm = {{11{sel[31]}}, sel[31], sel[19:12], sel[20], sel[30:21], 1'b0};
            7'b1100011: imm = {{19{sel[31]}}, sel[31], sel[7], sel[30:25], sel[11:8], 1'b0};
            7'b0100011: imm = {{20{sel[31]}}, sel[31:25], sel[11:7]};
            7'b0010011: imm = {{20{sel[31]}}, sel[31:20]};
            default:    imm = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid  <= 1'b0;
            dec_opcode <= `OPC_ADDI;
            dec_rd     <= '0;
            dec_rs1    <= '0;
            dec_rs2    <= '0;
        end else if (!mem_wait) begin
            dec_valid  <= fetch_valid && !flush;
            dec_opcode <= inst_key(sel);
            dec_rd     <= sel[11:7];
            dec_rs1    <= sel[19:15];
            dec_rs2    <= sel[24:20];
        end
    end

    always_ff @(posedge clk) begin
        if (!mem_wait) begin
            dec_pc  <= fetch_pc;
            dec_imm <= imm;
        end
    end

endmodule

`default_nettype wire

/* verilog/reg_file.sv */
`default_nettype none

module reg_file import core_pkg::*; (
    input  wire            clk,
    input  wire            arst_n,
    input  wire reg_addr_t rs1,
    input  wire reg_addr_t rs2,
    output word_t          rs1_data,
    output word_t          rs2_data,
    input  wire            ex_we,
    input  wire reg_addr_t ex_wa,
    input  wire word_t     ex_wd,
    input  wire            wb_we,
    input  wire reg_addr_t wb_wa,
    input  wire word_t     wb_wd
);

    word_t regs [1:31];

    // newest result wins, x0 never forwards
    function automatic word_t read_port(input reg_addr_t a);
        word_t d;
        if (a == '0) begin
            d = '0;
        end else if (ex_we && ex_wa == a) begin
            d = ex_wd;
        end else if (wb_we && wb_wa == a) begin
            d = wb_wd;
        end else begin
            d = regs[a];
        end
        return d;
    endfunction

    always_comb begin
        rs1_data = read_port(rs1);
        rs2_data = read_port(rs2);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we && wb_wa != '0) begin
            regs[wb_wa] <= wb_wd;
        end
    end

endmodule

`default_nettype wire

/* verilog/exec.sv */
`include "core_cfg.svh"
`default_nettype none

module exec import core_pkg::*; (
    input  wire            clk,
    input  wire            arst_n,
    input  wire            mem_wait,
    input  wire            dec_valid,
    input  wire word_t     dec_pc,
    input  wire opcode_t   dec_opcode,
    input  wire reg_addr_t dec_rd,
    input  wire word_t     dec_imm,
    input  wire word_t     rs1_data,
    input  wire word_t     rs2_data,
    output logic           flush,
    output word_t          flush_pc,
    output logic           ex_we,
    output reg_addr_t      ex_wa,
    output word_t          ex_wd,
    output logic           ex_st_en,
    output word_t          ex_st_addr,
    output word_t          ex_st_data
);

    logic      valid_q;
    logic      we_q;
    logic      st_q;
    logic      jmp_q;
    reg_addr_t wa_q;
    word_t     wd_q;
    word_t     st_addr_q;
    word_t     st_data_q;
    word_t     jmp_pc_q;
    logic      we_d;
    logic      st_d;
    logic      jmp_d;
    word_t     wd_d;

    always_comb begin
        we_d  = 1'b0;
        st_d  = 1'b0;
        jmp_d = 1'b0;
        wd_d  = '0;
        case (dec_opcode)
            `OPC_ADD:  begin we_d = 1'b1; wd_d = rs1_data + rs2_data; end
            `OPC_SUB:  begin we_d = 1'b1; wd_d = rs1_data - rs2_data; end
            `OPC_AND:  begin we_d = 1'b1; wd_d = rs1_data & rs2_data; end
            `OPC_OR:   begin we_d = 1'b1; wd_d = rs1_data | rs2_data; end
            `OPC_XOR:  begin we_d = 1'b1; wd_d = rs1_data ^ rs2_data; end
            `OPC_ADDI: begin we_d = 1'b1; wd_d = rs1_data + dec_imm; end
            `OPC_LUI:  begin we_d = 1'b1; wd_d = dec_imm; end
            // link value goes down with the jump
            `OPC_JAL:  begin we_d = 1'b1; jmp_d = 1'b1; wd_d = dec_pc + 32'd4; end
            `OPC_BEQ:  jmp_d = (rs1_data == rs2_data);
            `OPC_BNE:  jmp_d = (rs1_data != rs2_data);
            `OPC_SW:   st_d = 1'b1;
            default:   ;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
            we_q    <= 1'b0;
            st_q    <= 1'b0;
            jmp_q   <= 1'b0;
        end else if (!mem_wait) begin
            // the slot behind a taken jump is dropped
            valid_q <= dec_valid && !flush;
            we_q    <= we_d;
            st_q    <= st_d;
            jmp_q   <= jmp_d;
        end
    end

    always_ff @(posedge clk) begin
        if (!mem_wait) begin
            wa_q      <= dec_rd;
            wd_q      <= wd_d;
            st_addr_q <= rs1_data + dec_imm;
            st_data_q <= rs2_data;
            jmp_pc_q  <= dec_pc + dec_imm;
        end
    end

    // one pulse per jump, held off while memory waits
    assign flush      = valid_q && jmp_q && !mem_wait;
    assign flush_pc   = jmp_pc_q;
    assign ex_we      = valid_q && we_q;
    assign ex_wa      = wa_q;
    assign ex_wd      = wd_q;
    assign ex_st_en   = valid_q && st_q;
    assign ex_st_addr = st_addr_q;
    assign ex_st_data = st_data_q;

endmodule

`default_nettype wire

/* verilog/write_stage.sv */
`default_nettype none

module write_stage import core_pkg::*; (
    input  wire            clk,
    input  wire            arst_n,
    input  wire            mem_wait,
    input  wire            ex_we,
    input  wire reg_addr_t ex_wa,
    input  wire word_t     ex_wd,
    input  wire            ex_st_en,
    input  wire word_t     ex_st_addr,
    input  wire word_t     ex_st_data,
    output logic           wb_we,
    output reg_addr_t      wb_wa,
    output word_t          wb_wd,
    output logic           data_wren,
    output strb_t          data_wstrb,
    output word_t          data_waddr,
    output word_t          data_wdata
);

    logic  we_q;
    logic  st_q;
    word_t addr_q;
    word_t data_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            we_q <= 1'b0;
            st_q <= 1'b0;
        end else if (!mem_wait) begin
            we_q <= ex_we;
            st_q <= ex_st_en;
        end
    end

    always_ff @(posedge clk) begin
        if (!mem_wait) begin
            wb_wa  <= ex_wa;
            wb_wd  <= ex_wd;
            addr_q <= ex_st_addr;
            data_q <= ex_st_data;
        end
    end

    // performed in the single cycle the hold is released
    assign wb_we      = we_q && !mem_wait;
    assign data_wren  = st_q && !mem_wait;
    // word stores only
    assign data_wstrb = {4{data_wren}};
    assign data_waddr = addr_q;
    assign data_wdata = data_q;

endmodule

`default_nettype wire

/* verilog/main.sv */
`include "core_cfg.svh"
`default_nettype none

module main import core_pkg::*; #(
    parameter word_t start_addr = `START_ADDR
) (
    input  wire        clk,
    input  wire        arst_n,
    output logic       inst_rden,
    output word_t      inst_riaddr,
    input  wire word_t inst_roaddr,
    input  wire        inst_rvalid,
    input  wire word_t inst_rdata,
    output logic       data_wren,
    output strb_t      data_wstrb,
    output word_t      data_waddr,
    output word_t      data_wdata,
    input  wire        mem_wait
);

    logic      flush;
    word_t     flush_pc;

    logic      fetch_valid;
    word_t     fetch_pc;
    word_t     fetch_inst;

    logic      dec_valid;
    word_t     dec_pc;
    opcode_t   dec_opcode;
    reg_addr_t dec_rd;
    reg_addr_t dec_rs1;
    reg_addr_t dec_rs2;
    word_t     dec_imm;
    word_t     rs1_data;
    word_t     rs2_data;

    logic      ex_we;
    reg_addr_t ex_wa;
    word_t     ex_wd;
    logic      ex_st_en;
    word_t     ex_st_addr;
    word_t     ex_st_data;

    logic      wb_we;
    reg_addr_t wb_wa;
    word_t     wb_wd;

    fetch #(
        .start_addr  (start_addr)
    ) u_fetch (
        .clk         (clk),
        .arst_n      (arst_n),
        .mem_wait    (mem_wait),
        .flush       (flush),
        .flush_pc    (flush_pc),
        .inst_rden   (inst_rden),
        .inst_riaddr (inst_riaddr),
        .inst_rvalid (inst_rvalid),
        .inst_roaddr (inst_roaddr),
        .inst_rdata  (inst_rdata),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_inst  (fetch_inst)
    );

    decode u_decode (
        .clk         (clk),
        .arst_n      (arst_n),
        .mem_wait    (mem_wait),
        .flush       (flush),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_inst  (fetch_inst),
        .dec_valid   (dec_valid),
        .dec_pc      (dec_pc),
        .dec_opcode  (dec_opcode),
        .dec_rd      (dec_rd),
        .dec_rs1     (dec_rs1),
        .dec_rs2     (dec_rs2),
        .dec_imm     (dec_imm)
    );

    // read at the decode register, forwarded from both later stages
    reg_file u_reg_file (
        .clk         (clk),
        .arst_n      (arst_n),
        .rs1         (dec_rs1),
        .rs2         (dec_rs2),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .ex_we       (ex_we),
        .ex_wa       (ex_wa),
        .ex_wd       (ex_wd),
        .wb_we       (wb_we),
        .wb_wa       (wb_wa),
        .wb_wd       (wb_wd)
    );

    exec u_exec (
        .clk         (clk),
        .arst_n      (arst_n),
        .mem_wait    (mem_wait),
        .dec_valid   (dec_valid),
        .dec_pc      (dec_pc),
        .dec_opcode  (dec_opcode),
        .dec_rd      (dec_rd),
        .dec_imm     (dec_imm),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .flush       (flush),
        .flush_pc    (flush_pc),
        .ex_we       (ex_we),
        .ex_wa       (ex_wa),
        .ex_wd       (ex_wd),
        .ex_st_en    (ex_st_en),
        .ex_st_addr  (ex_st_addr),
        .ex_st_data  (ex_st_data)
    );

    write_stage u_write_stage (
        .clk         (clk),
        .arst_n      (arst_n),
        .mem_wait    (mem_wait),
        .ex_we       (ex_we),
        .ex_wa       (ex_wa),
        .ex_wd       (ex_wd),
        .ex_st_en    (ex_st_en),
        .ex_st_addr  (ex_st_addr),
        .ex_st_data  (ex_st_data),
        .wb_we       (wb_we),
        .wb_wa       (wb_wa),
        .wb_wd       (wb_wd),
        .data_wren   (data_wren),
        .data_wstrb  (data_wstrb),
        .data_waddr  (data_waddr),
        .data_wdata  (data_wdata)
    );

endmodule

`default_nettype wire

/* test/main_asserts.sv */
`default_nettype none

module main_asserts (
    input wire clk,
    input wire arst_n,
    input wire mem_wait,
    input wire inst_rden,
    input wire data_wren
);

    timeunit 1ns;
    timeprecision 1ps;

    // stores only in cycles the memory accepts them
    store_hold: assert property (@(posedge clk) disable iff (!arst_n)
        mem_wait |-> !data_wren)
        else $error("data_wren high while mem_wait is high");

    fetch_hold: assert property (@(posedge clk) disable iff (!arst_n)
        mem_wait |-> !inst_rden)
        else $error("inst_rden high while mem_wait is high");

    reset_quiet: assert property (@(posedge clk)
        !arst_n |-> !data_wren)
        else $error("data_wren high during reset");

endmodule

`default_nettype wire

/* test/main_tb.sv */
`include "core_cfg.svh"
`default_nettype none

module main_tb
    import core_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [11:0] POISON_ADDR = 12'h7FC;

    typedef enum logic [3:0] {
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_LUI,
        OP_JAL, OP_BEQ, OP_BNE, OP_X0
    } op_e;

    typedef struct packed {
        op_e         op;
        logic [19:0] a;
        logic [11:0] b;
        logic [11:0] addr;
    } row_t;

    // op, a, b, store address
    row_t rows [13] = '{
        '{OP_ADD,  20'h00123, 12'h045, 12'h100},
        '{OP_SUB,  20'h00010, 12'h7FF, 12'h104},
        '{OP_AND,  20'h00F0F, 12'h3C3, 12'h108},
        '{OP_OR,   20'h00505, 12'hA0A, 12'h10C},
        '{OP_XOR,  20'h00FFF, 12'h555, 12'h110},
        '{OP_ADDI, 20'h007FF, 12'h801, 12'h114},
        '{OP_LUI,  20'hABCDE, 12'h000, 12'h118},
        '{OP_JAL,  20'h00001, 12'h002, 12'h11C},
        '{OP_BEQ,  20'h00005, 12'h005, 12'h120},
        '{OP_BEQ,  20'h00005, 12'h006, 12'h128},
        '{OP_BNE,  20'h00007, 12'h009, 12'h130},
        '{OP_BNE,  20'h00003, 12'h003, 12'h138},
        '{OP_X0,   20'h000AA, 12'h011, 12'h140}
    };

    logic      clk;
    logic      arst_n;
    logic      mem_wait;
    logic      inst_rvalid;
    word_t     inst_roaddr;
    word_t     inst_rdata;
    logic      inst_rden;
    word_t     inst_riaddr;
    logic      data_wren;
    strb_t     data_wstrb;
    word_t     data_waddr;
    word_t     data_wdata;

    word_t     imem [0:255];
    word_t     exp_addr_q [$];
    word_t     exp_data_q [$];
    int        exp_idx;
    logic      req_pend;
    word_t     req_addr;
    logic      wait_rand;
    integer    seed = 86895;

    main #(
        .start_addr  (`START_ADDR)
    ) dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .inst_rden   (inst_rden),
        .inst_riaddr (inst_riaddr),
        .inst_roaddr (inst_roaddr),
        .inst_rvalid (inst_rvalid),
        .inst_rdata  (inst_rdata),
        .data_wren   (data_wren),
        .data_wstrb  (data_wstrb),
        .data_waddr  (data_waddr),
        .data_wdata  (data_wdata),
        .mem_wait    (mem_wait)
    );

    bind main main_asserts u_asserts (
        .clk       (clk),
        .arst_n    (arst_n),
        .mem_wait  (mem_wait),
        .inst_rden (inst_rden),
        .data_wren (data_wren)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_equal(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic word_t rtype_inst(input logic [6:0] f7, input logic [2:0] f3,
                                         input reg_addr_t rd, input reg_addr_t rs1,
                                         input reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t addi_inst(input reg_addr_t rd, input reg_addr_t rs1,
                                        input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic word_t store_inst(input reg_addr_t rs2, input reg_addr_t rs1,
                                         input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t branch_inst(input logic [2:0] f3, input reg_addr_t rs1,
                                          input reg_addr_t rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic word_t jal_inst(input reg_addr_t rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic word_t lui_inst(input reg_addr_t rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic word_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic word_t alu_result(input row_t r);
        word_t x;
        word_t y;
        word_t res;
        x = sext12(r.a[11:0]);
        y = sext12(r.b);
        case (r.op)
            OP_ADD, OP_ADDI: res = x + y;
            OP_SUB:          res = x - y;
            OP_AND:          res = x & y;
            OP_OR:           res = x | y;
            OP_XOR:          res = x ^ y;
            OP_LUI:          res = {r.a, 12'b0};
            // x0 is hardwired to zero
            default:         res = '0;
        endcase
        return res;
    endfunction

    function automatic logic branch_taken(input row_t r);
        if (r.op == OP_BEQ) begin
            return r.a[11:0] == r.b;
        end
        return r.a[11:0] != r.b;
    endfunction

    task automatic place(inout word_t pc, input word_t inst);
        imem[pc[9:2]] = inst;
        pc = pc + 32'd4;
    endtask

    task automatic expect_store(input word_t addr, input word_t data);
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(data);
    endtask

    task automatic build_program();
        word_t pc;
        word_t link;
        row_t  r;
        // unused words are addi x0,x0,<word index>
        for (int i = 0; i < 256; i++) begin
            imem[i] = {i[11:0], 13'b0, 7'b0010011};
        end
        pc = `START_ADDR;
        foreach (rows[i]) begin
            r = rows[i];
            place(pc, addi_inst(5'd1, 5'd0, r.a[11:0]));
            place(pc, addi_inst(5'd2, 5'd0, r.b));
            if (r.op == OP_JAL) begin
                link = pc + 32'd4;
                place(pc, jal_inst(5'd3, 21'd8));
                place(pc, store_inst(5'd1, 5'd0, POISON_ADDR));
                place(pc, store_inst(5'd3, 5'd0, r.addr));
                expect_store({20'b0, r.addr}, link);
            end else if (r.op == OP_BEQ || r.op == OP_BNE) begin
                place(pc, branch_inst((r.op == OP_BEQ) ? 3'b000 : 3'b001, 5'd1, 5'd2, 13'd8));
                // the skipped slot only hits the poison address when the branch is taken
                place(pc, store_inst(5'd1, 5'd0, branch_taken(r) ? POISON_ADDR : r.addr));
                place(pc, store_inst(5'd2, 5'd0, r.addr + 12'd4));
                if (!branch_taken(r)) begin
                    expect_store({20'b0, r.addr}, sext12(r.a[11:0]));
                end
                expect_store({20'b0, r.addr + 12'd4}, sext12(r.b));
            end else begin
                case (r.op)
                    OP_ADD:  place(pc, rtype_inst(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
                    OP_SUB:  place(pc, rtype_inst(7'h20, 3'b000, 5'd3, 5'd1, 5'd2));
                    OP_AND:  place(pc, rtype_inst(7'h00, 3'b111, 5'd3, 5'd1, 5'd2));
                    OP_OR:   place(pc, rtype_inst(7'h00, 3'b110, 5'd3, 5'd1, 5'd2));
                    OP_XOR:  place(pc, rtype_inst(7'h00, 3'b100, 5'd3, 5'd1, 5'd2));
                    OP_ADDI: place(pc, addi_inst(5'd3, 5'd1, r.b));
                    OP_LUI:  place(pc, lui_inst(5'd3, r.a));
                    default: place(pc, addi_inst(5'd0, 5'd1, r.b));
                endcase
                place(pc, store_inst((r.op == OP_X0) ? 5'd0 : 5'd3, 5'd0, r.addr));
                expect_store({20'b0, r.addr}, alu_result(r));
            end
        end
        // park the core in a self loop
        place(pc, jal_inst(5'd0, 21'd0));
    endtask

    // memory answer and hold pattern, driven after the edge
    initial begin
        mem_wait    = 1'b0;
        inst_rvalid = 1'b0;
        inst_roaddr = '0;
        inst_rdata  = '0;
        forever begin
            @(posedge clk);
            #2;
            inst_rvalid = req_pend;
            inst_roaddr = req_addr;
            inst_rdata  = imem[req_addr[9:2]];
            mem_wait    = wait_rand && (($random(seed) & 3) == 0);
        end
    end

    // requests and stores are sampled mid cycle
    always @(negedge clk) begin
        if (!arst_n) begin
            req_pend = 1'b0;
            exp_idx  = 0;
        end else begin
            req_pend = inst_rden;
            req_addr = inst_riaddr;
            if (data_wren) begin
                if (exp_idx >= exp_addr_q.size()) begin
                    abort_run($sformatf("unexpected store to %h", data_waddr));
                end else begin
                    check_equal("store address", data_waddr, exp_addr_q[exp_idx]);
                    check_equal("store data", data_wdata, exp_data_q[exp_idx]);
                    check_equal("store strobe", {28'b0, data_wstrb}, 32'hF);
                    exp_idx++;
                end
            end
        end
    end

    task automatic run_pass(input logic random_wait);
        int cycles;
        wait_rand = 1'b0;
        @(posedge clk);
        #2;
        arst_n = 1'b0;
        repeat (16) @(posedge clk);
        #2;
        arst_n = 1'b1;
        cycles = 0;
        @(negedge clk);
        while (!inst_rden) begin
            cycles++;
            if (cycles > 10) begin
                abort_run("no instruction request after reset");
            end
            @(negedge clk);
        end
        check_equal("first fetch address", inst_riaddr, `START_ADDR);
        wait_rand = random_wait;
        cycles = 0;
        while (exp_idx < exp_addr_q.size()) begin
            cycles++;
            if (cycles > 5000) begin
                abort_run($sformatf("only %0d of %0d stores seen", exp_idx, exp_addr_q.size()));
            end
            @(posedge clk);
        end
        // stray or repeated stores show up here
        repeat (40) @(posedge clk);
        $display("pass done with %0d stores checked", exp_idx);
    endtask

    initial begin
        arst_n    = 1'b0;
        wait_rand = 1'b0;
        req_pend  = 1'b0;
        req_addr  = '0;
        build_program();
        run_pass(1'b0);
        run_pass(1'b1);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+verilog
verilog/core_pkg.sv
verilog/fetch.sv
verilog/decode.sv
verilog/reg_file.sv
verilog/exec.sv
verilog/write_stage.sv
verilog/main.sv
test/main_asserts.sv
test/main_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= main_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

FILELIST  := build.f
SRCS      := $(shell grep -v '^+' $(FILELIST))
HDRS      := $(wildcard verilog/*.svh)
BIN       := $(OBJ_DIR)/V$(TOP)
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
